/* hdl/mp3_frame_pkg.sv */
package mp3_frame_pkg;

	// ==============================
	// Granule geometry
	// ==============================

	localparam int SAMPLE_W     = 18;
	localparam int GRANULE_SIZE = 576;
	localparam int ADDR_W       = 10;
	localparam int SUBBAND_LEN  = 18;
	localparam int NUM_SUBBANDS = 32;

	// ==============================
	// Stereo decoding
	// ==============================

	// 1/sqrt(2) in Q17
	localparam int INV_SQRT2       = 92682;
	localparam int INV_SQRT2_SHIFT = 17;

	localparam logic [1:0] MODE_JOINT_STEREO = 2'd1;
	localparam int         MS_EXT_BIT        = 1;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [ADDR_W-1:0] addr_t;

	typedef struct packed {
		sample_t ch0;
		sample_t ch1;
	} sample_pair_t;

	// Both channels share address and enable
	typedef struct packed {
		logic         we;
		addr_t        addr;
		sample_pair_t data;
	} granule_wr_t;

	// Header fields that ride along with each granule
	typedef struct packed {
		logic [1:0] mode;
		logic [1:0] mode_extension;
		logic [1:0] sampling_frequency;
	} frame_param_t;

endpackage

/* hdl/chain_ctrl_pkg.sv */
package chain_ctrl_pkg;

	// ==============================
	// Event system layout
	// ==============================

	localparam int STAGES     = 4;
	localparam int NUM_SWITCH = STAGES - 1;

	// Stage indices along the chain
	localparam int STG_PRODUCER = 0;
	localparam int STG_STEREO   = 1;
	localparam int STG_FREQ_INV = 2;
	localparam int STG_PCM      = 3;

	typedef logic [STAGES-1:0] stage_vec_t;

endpackage

/* hdl/stage_sequencer.sv */
module stage_sequencer
	import chain_ctrl_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  stage_vec_t            stage_done,
	output stage_vec_t            stage_ready,
	output logic [NUM_SWITCH-1:0] buffer_switch
);

	stage_vec_t done_flags;
	logic       all_done;

	// Includes pulses arriving this cycle
	assign all_done = &(done_flags | stage_done);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_flags    <= '1;
			buffer_switch <= '0;
			stage_ready   <= '0;
		end else begin
			// Ready follows the switch by one cycle
			stage_ready <= {STAGES{buffer_switch[0]}};
			if (all_done) begin
				done_flags    <= '0;
				buffer_switch <= '1;
			end else begin
				done_flags    <= done_flags | stage_done;
				buffer_switch <= '0;
			end
		end
	end

	// ==============================
	// Checks
	// ==============================

	// A stage may not finish in the switch cycle, before it was told to start
	ready_switch_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(|stage_ready && |buffer_switch)
	) else $error("stage_ready and buffer_switch high together");

	// One done pulse per stage and round
	single_done_per_round: assert property (
		@(posedge clk) disable iff (!rst_n)
		(stage_done & done_flags) == '0
	) else $error("stage_done %b repeated, flags %b", stage_done, done_flags);

endmodule

/* hdl/stage_buffer.sv */
module stage_buffer
	import mp3_frame_pkg::*;
#(
	parameter bit HAS_PARAM = 1'b0
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         swap,
	input  granule_wr_t  wr,
	input  addr_t        rd_addr,
	output sample_pair_t rd_data,
	input  logic         param_we,
	input  frame_param_t param_in,
	output frame_param_t param_out
);

	logic wr_bank;
	logic rd_bank;

	sample_pair_t mem [2][GRANULE_SIZE];

	assign rd_bank = ~wr_bank;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_bank <= 1'b0;
		end else if (swap) begin
			wr_bank <= ~wr_bank;
		end
	end

	// ==============================
	// Granule banks
	// ==============================

	always_ff @(posedge clk) begin
		if (wr.we) begin
			mem[wr_bank][wr.addr] <= wr.data;
		end
		rd_data <= mem[rd_bank][rd_addr];
	end

	// ==============================
	// Frame parameters
	// ==============================

	generate
		if (HAS_PARAM) begin : g_param
			frame_param_t param_q [2];

			// Swaps together with the sample banks
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					param_q[0] <= '0;
					param_q[1] <= '0;
				end else if (param_we) begin
					param_q[wr_bank] <= param_in;
				end
			end

			assign param_out = param_q[rd_bank];
		end else begin : g_no_param
			assign param_out = '0;
		end
	endgenerate

	// Writers come from outside or the previous stage
	wr_addr_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr.we |-> (wr.addr < GRANULE_SIZE)
	) else $error("write address %0d out of granule", wr.addr);

endmodule

/* hdl/ms_stereo_stage.sv */
module ms_stereo_stage
	import mp3_frame_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         ready,
	output logic         done,
	output addr_t        rd_addr,
	input  sample_pair_t rd_data,
	input  frame_param_t param,
	output granule_wr_t  wr
);

	logic  active;
	logic  wr_valid;
	addr_t wr_addr_q;
	logic  ms_en;

	logic signed [SAMPLE_W:0]     sum_s;
	logic signed [SAMPLE_W:0]     diff_s;
	logic signed [2*SAMPLE_W+1:0] mid_prod;
	logic signed [2*SAMPLE_W+1:0] side_prod;

	// ==============================
	// Address walk
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active   <= 1'b0;
			rd_addr  <= '0;
			wr_valid <= 1'b0;
			done     <= 1'b0;
		end else begin
			wr_valid <= active;
			done     <= wr_valid && (wr_addr_q == addr_t'(GRANULE_SIZE - 1));
			if (ready) begin
				active  <= 1'b1;
				rd_addr <= '0;
			end else if (active) begin
				if (rd_addr == addr_t'(GRANULE_SIZE - 1)) begin
					active <= 1'b0;
				end else begin
					rd_addr <= rd_addr + 1'b1;
				end
			end
		end
	end

	// Write address trails the read by the RAM latency
	always_ff @(posedge clk) begin
		wr_addr_q <= rd_addr;
	end

	// ==============================
	// Mid/side reconstruction
	// ==============================

	assign ms_en = (param.mode == MODE_JOINT_STEREO) && param.mode_extension[MS_EXT_BIT];

	always_comb begin
		sum_s     = rd_data.ch0 + rd_data.ch1;
		diff_s    = rd_data.ch0 - rd_data.ch1;
		mid_prod  = sum_s * INV_SQRT2;
		side_prod = diff_s * INV_SQRT2;

		wr.we   = wr_valid;
		wr.addr = wr_addr_q;
		if (ms_en) begin
			wr.data.ch0 = sample_t'(mid_prod >>> INV_SQRT2_SHIFT);
			wr.data.ch1 = sample_t'(side_prod >>> INV_SQRT2_SHIFT);
		end else begin
			wr.data = rd_data;
		end
	end

	done_after_walk: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |-> !active
	) else $error("done raised during granule walk");

endmodule

/* hdl/freq_inversion_stage.sv */
module freq_inversion_stage
	import mp3_frame_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         ready,
	output logic         done,
	output addr_t        rd_addr,
	input  sample_pair_t rd_data,
	output granule_wr_t  wr
);

	logic [$clog2(NUM_SUBBANDS)-1:0] subband;
	logic [$clog2(SUBBAND_LEN)-1:0]  pos;

	logic  active;
	logic  last;
	logic  wr_valid;
	logic  wr_last;
	logic  invert_q;
	addr_t wr_addr_q;

	assign last = (subband == NUM_SUBBANDS - 1) && (pos == SUBBAND_LEN - 1);

	// ==============================
	// Subband walk
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active   <= 1'b0;
			rd_addr  <= '0;
			subband  <= '0;
			pos      <= '0;
			wr_valid <= 1'b0;
			wr_last  <= 1'b0;
			done     <= 1'b0;
		end else begin
			wr_valid <= active;
			wr_last  <= active && last;
			done     <= wr_last;
			if (ready) begin
				active  <= 1'b1;
				rd_addr <= '0;
				subband <= '0;
				pos     <= '0;
			end else if (active) begin
				if (last) begin
					active <= 1'b0;
				end else begin
					rd_addr <= rd_addr + 1'b1;
					if (pos == SUBBAND_LEN - 1) begin
						pos     <= '0;
						subband <= subband + 1'b1;
					end else begin
						pos <= pos + 1'b1;
					end
				end
			end
		end
	end

	// Odd sample of an odd subband
	always_ff @(posedge clk) begin
		wr_addr_q <= rd_addr;
		invert_q  <= subband[0] & pos[0];
	end

	always_comb begin
		wr.we   = wr_valid;
		wr.addr = wr_addr_q;
		if (invert_q) begin
			wr.data.ch0 = -rd_data.ch0;
			wr.data.ch1 = -rd_data.ch1;
		end else begin
			wr.data = rd_data;
		end
	end

endmodule

/* hdl/decoding_chain.sv */
module decoding_chain
	import mp3_frame_pkg::*;
	import chain_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  granule_wr_t  granule_wr,
	input  logic         param_we,
	input  frame_param_t param_data,
	output logic         stage_ready,
	input  logic         stage_done,
	input  addr_t        pcm_read_addr,
	output sample_pair_t pcm_read_data,
	output logic         pcm_ready,
	input  logic         pcm_done
);

	stage_vec_t            seq_done;
	stage_vec_t            seq_ready;
	logic [NUM_SWITCH-1:0] seq_switch;

	logic         ms_done;
	addr_t        ms_rd_addr;
	sample_pair_t ms_rd_data;
	frame_param_t ms_param;
	granule_wr_t  ms_wr;

	logic         fi_done;
	addr_t        fi_rd_addr;
	sample_pair_t fi_rd_data;
	granule_wr_t  fi_wr;

	// ==============================
	// Event system
	// ==============================

	assign seq_done[STG_PRODUCER] = stage_done;
	assign seq_done[STG_STEREO]   = ms_done;
	assign seq_done[STG_FREQ_INV] = fi_done;
	assign seq_done[STG_PCM]      = pcm_done;

	assign stage_ready = seq_ready[STG_PRODUCER];
	assign pcm_ready   = seq_ready[STG_PCM];

	stage_sequencer sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.stage_done(seq_done),
		.stage_ready(seq_ready),
		.buffer_switch(seq_switch)
	);

	// ==============================
	// Mid/side stereo
	// ==============================

	stage_buffer #(
		.HAS_PARAM(1'b1)
	) stereo_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.swap(seq_switch[STG_PRODUCER]),
		.wr(granule_wr),
		.rd_addr(ms_rd_addr),
		.rd_data(ms_rd_data),
		.param_we(param_we),
		.param_in(param_data),
		.param_out(ms_param)
	);

	ms_stereo_stage ms_stage (
		.clk(clk),
		.rst_n(rst_n),
		.ready(seq_ready[STG_STEREO]),
		.done(ms_done),
		.rd_addr(ms_rd_addr),
		.rd_data(ms_rd_data),
		.param(ms_param),
		.wr(ms_wr)
	);

	// ==============================
	// Frequency inversion
	// ==============================

	stage_buffer #(
		.HAS_PARAM(1'b0)
	) freq_inv_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.swap(seq_switch[STG_STEREO]),
		.wr(ms_wr),
		.rd_addr(fi_rd_addr),
		.rd_data(fi_rd_data),
		.param_we(1'b0),
		.param_in('0),
		.param_out()
	);

	freq_inversion_stage fi_stage (
		.clk(clk),
		.rst_n(rst_n),
		.ready(seq_ready[STG_FREQ_INV]),
		.done(fi_done),
		.rd_addr(fi_rd_addr),
		.rd_data(fi_rd_data),
		.wr(fi_wr)
	);

	// PCM output read from outside
	stage_buffer #(
		.HAS_PARAM(1'b0)
	) pcm_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.swap(seq_switch[STG_FREQ_INV]),
		.wr(fi_wr),
		.rd_addr(pcm_read_addr),
		.rd_data(pcm_read_data),
		.param_we(1'b0),
		.param_in('0),
		.param_out()
	);

endmodule

/* verif/clk_gen.sv */
module clk_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release lands on a rising edge, after the flops have sampled it low
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* verif/tb_decoding_chain.sv */
module tb_decoding_chain
	import mp3_frame_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD_NS = 4;
	localparam int RESET_CYCLES  = 5;
	localparam int ROUND_CYCLES  = 700;
	localparam int NUM_ROUNDS    = 20;
	localparam int HOLD_CYCLES   = 2000;
	localparam int SAMPLE_LIMIT  = 1 << 15;
	localparam int RANDOM_SEED   = 16321;

	logic         clk;
	logic         rst_n;
	granule_wr_t  granule_wr;
	logic         param_we;
	frame_param_t param_data;
	logic         stage_ready;
	logic         stage_done;
	addr_t        pcm_read_addr;
	sample_pair_t pcm_read_data;
	logic         pcm_ready;
	logic         pcm_done;

	// One expected PCM granule per round in flight
	sample_pair_t exp_mem [4][GRANULE_SIZE];
	bit           exp_valid [4];
	sample_pair_t pcm_seen [GRANULE_SIZE];
	int           round_idx;

	clk_gen #(
		.PERIOD_NS(CLK_PERIOD_NS),
		.RESET_CYCLES(RESET_CYCLES)
	) clock_source (
		.clk(clk),
		.rst_n(rst_n)
	);

	decoding_chain UUT (
		.clk(clk),
		.rst_n(rst_n),
		.granule_wr(granule_wr),
		.param_we(param_we),
		.param_data(param_data),
		.stage_ready(stage_ready),
		.stage_done(stage_done),
		.pcm_read_addr(pcm_read_addr),
		.pcm_read_data(pcm_read_data),
		.pcm_ready(pcm_ready),
		.pcm_done(pcm_done)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	// ==============================
	// Reference model
	// ==============================

	function automatic frame_param_t make_frame(input logic [1:0] mode, input logic [1:0] ext,
			input logic [1:0] sf);
		frame_param_t fp;
		fp.mode               = mode;
		fp.mode_extension     = ext;
		fp.sampling_frequency = sf;
		return fp;
	endfunction

	function automatic sample_t random_sample();
		int v;
		v = int'($urandom_range(2 * SAMPLE_LIMIT)) - SAMPLE_LIMIT;
		return sample_t'(v);
	endfunction

	function automatic sample_pair_t ms_rule(input sample_pair_t in, input frame_param_t fp);
		sample_pair_t res;
		longint       sum;
		longint       diff;
		res = in;
		if (fp.mode == MODE_JOINT_STEREO && fp.mode_extension[MS_EXT_BIT]) begin
			sum     = longint'(in.ch0) + longint'(in.ch1);
			diff    = longint'(in.ch0) - longint'(in.ch1);
			res.ch0 = sample_t'((sum * INV_SQRT2) >>> INV_SQRT2_SHIFT);
			res.ch1 = sample_t'((diff * INV_SQRT2) >>> INV_SQRT2_SHIFT);
		end
		return res;
	endfunction

	function automatic sample_pair_t fi_rule(input sample_pair_t in, input int addr);
		sample_pair_t res;
		res = in;
		if ((addr / SUBBAND_LEN) % 2 == 1 && (addr % SUBBAND_LEN) % 2 == 1) begin
			res.ch0 = -in.ch0;
			res.ch1 = -in.ch1;
		end
		return res;
	endfunction

	// ==============================
	// Round handling
	// ==============================

	task automatic wait_for_ready();
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			assert (pcm_ready === stage_ready) else abort_run($sformatf(
				"Fail pcm_ready: got %h, expected %h", pcm_ready, stage_ready));
			if (waited > ROUND_CYCLES)
				abort_run("no stage_ready pulse arrived after all stages were done");
		end while (stage_ready !== 1'b1);
		round_idx++;
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (stage_ready === 1'b0 && pcm_ready === 1'b0)
				else abort_run("ready pulse while a stage still held back its done");
		end
	endtask

	task automatic pulse_done(input logic prod, input logic pcm);
		stage_done = prod;
		pcm_done   = pcm;
		@(negedge clk);
		stage_done = 1'b0;
		pcm_done   = 1'b0;
	endtask

	// Writes one granule and reads the PCM buffer in the same pass
	task automatic process_round(input logic do_write, input frame_param_t fp);
		int           wr_slot;
		int           rd_slot;
		bit           check;
		sample_pair_t src;
		wr_slot            = round_idx % 4;
		rd_slot            = (round_idx + 1) % 4;
		check              = exp_valid[rd_slot];
		exp_valid[wr_slot] = do_write;
		for (int i = 0; i <= GRANULE_SIZE; i++) begin
			if (i > 0) begin
				@(negedge clk);
				pcm_seen[i-1] = pcm_read_data;
				if (check) begin
					assert (pcm_read_data === exp_mem[rd_slot][i-1]) else abort_run($sformatf(
						"Fail pcm_read_data[%0d]: got %h, expected %h",
						i - 1, pcm_read_data, exp_mem[rd_slot][i-1]));
				end
			end
			param_we   = do_write && (i == 0);
			param_data = fp;
			if (i < GRANULE_SIZE) begin
				src.ch0       = random_sample();
				src.ch1       = random_sample();
				granule_wr.we   = do_write;
				granule_wr.addr = addr_t'(i);
				granule_wr.data = src;
				pcm_read_addr   = addr_t'(i);
				if (do_write)
					exp_mem[wr_slot][i] = fi_rule(ms_rule(src, fp), i);
			end else begin
				granule_wr = '0;
			end
		end
		exp_valid[rd_slot] = 1'b0;
	endtask

	task automatic finish_round();
		pulse_done(1'b1, 1'b1);
		wait_for_ready();
	endtask

	task automatic flush_pipeline();
		while (exp_valid[0] || exp_valid[1] || exp_valid[2] || exp_valid[3]) begin
			process_round(1'b0, '0);
			finish_round();
		end
	endtask

	task automatic read_pcm_again();
		for (int i = 0; i <= GRANULE_SIZE; i++) begin
			if (i > 0) begin
				@(negedge clk);
				assert (pcm_read_data === pcm_seen[i-1]) else abort_run($sformatf(
					"Fail pcm_read_data[%0d] on re-read: got %h, expected %h",
					i - 1, pcm_read_data, pcm_seen[i-1]));
			end
			if (i < GRANULE_SIZE)
				pcm_read_addr = addr_t'(i);
		end
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic ready_pulse_order();
		@(negedge clk);
		while (rst_n !== 1'b1) begin
			assert (stage_ready === 1'b0 && pcm_ready === 1'b0)
				else abort_run("ready pulse while reset was asserted");
			@(negedge clk);
		end
		wait_for_ready();
		// Consumer done first while the producer is still busy
		pulse_done(1'b0, 1'b1);
		expect_quiet(GRANULE_SIZE + 24);
		pulse_done(1'b1, 1'b0);
		wait_for_ready();
	endtask

	task automatic decode_plain_frame();
		process_round(1'b1, make_frame(2'd0, 2'b00, 2'd0));
		finish_round();
		flush_pipeline();
	endtask

	task automatic decode_joint_stereo();
		process_round(1'b1, make_frame(MODE_JOINT_STEREO, 2'b10, 2'd1));
		finish_round();
		process_round(1'b1, make_frame(MODE_JOINT_STEREO, 2'b01, 2'd1));
		finish_round();
		flush_pipeline();
	endtask

	task automatic track_frame_params();
		process_round(1'b1, make_frame(MODE_JOINT_STEREO, 2'b11, 2'd0));
		finish_round();
		process_round(1'b1, make_frame(2'd0, 2'b10, 2'd2));
		finish_round();
		process_round(1'b1, make_frame(MODE_JOINT_STEREO, 2'b10, 2'd1));
		finish_round();
		flush_pipeline();
	endtask

	task automatic hold_consumer_done();
		process_round(1'b1, make_frame(MODE_JOINT_STEREO, 2'b10, 2'd2));
		pulse_done(1'b1, 1'b0);
		expect_quiet(HOLD_CYCLES);
		read_pcm_again();
		pulse_done(1'b0, 1'b1);
		wait_for_ready();
		flush_pipeline();
	endtask

	initial begin
		granule_wr    = '0;
		param_we      = 1'b0;
		param_data    = '0;
		stage_done    = 1'b0;
		pcm_read_addr = '0;
		pcm_done      = 1'b0;
		round_idx     = -1;
		void'($urandom(RANDOM_SEED));
		ready_pulse_order();
		decode_plain_frame();
		decode_joint_stereo();
		track_frame_params();
		hold_consumer_done();
		$display("Test completed successfully");
		$finish;
	end

	// Covers all rounds plus the held stretch and its re-read
	initial begin
		#((NUM_ROUNDS * ROUND_CYCLES + HOLD_CYCLES + GRANULE_SIZE) * CLK_PERIOD_NS);
		abort_run("watchdog expired before the tests finished");
	end

endmodule

/* tb.f */
hdl/mp3_frame_pkg.sv
hdl/chain_ctrl_pkg.sv
hdl/stage_sequencer.sv
hdl/stage_buffer.sv
hdl/ms_stereo_stage.sv
hdl/freq_inversion_stage.sv
hdl/decoding_chain.sv
verif/clk_gen.sv
verif/tb_decoding_chain.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decoding_chain
FLAGS     ?= -Wno-fatal
OBJ_DIR   ?= obj_dir

FILELIST := tb.f
SOURCES  := $(shell cat $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --assert $(FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
